// ==== common/iq_pkg.sv ====
package iq_pkg;

    // queue geometry
    localparam int DEPTH = 8;
    // occupancy count that holds 0 to DEPTH
    localparam int DEPTH_W = 4;
    // entry index inside the queue
    localparam int IDX_W = 3;
    localparam int ISSUE_WIDTH = 2;
    localparam int WAKE_WIDTH = 2;

    // datapath widths
    localparam int PHY_W = 5;
    localparam int ROB_W = 5;
    localparam int DATA_W = 32;

    // execute units per class
    localparam int ALU_NUM = 2;
    localparam int MUL_NUM = 1;
    localparam int LSU_NUM = 1;

    typedef enum logic [1:0] {
        alu = 2'd0,
        mul = 2'd1,
        lsu = 2'd2
    } op_unit_t;

    // one source operand whose value only means something once loaded
    typedef struct packed {
        logic [PHY_W-1:0]  phy;
        logic              loaded;
        logic [DATA_W-1:0] value;
    } operand_t;

    typedef struct packed {
        logic [ROB_W-1:0] rob_id;
        op_unit_t         unit;
        operand_t         src1;
        operand_t         src2;
    } iq_item_t;

    // result broadcast from one producer
    typedef struct packed {
        logic              valid;
        logic [PHY_W-1:0]  phy;
        logic [DATA_W-1:0] value;
    } wake_t;

    typedef wake_t [WAKE_WIDTH-1:0] wake_bus_t;

    // one bit per unit that is high when the unit can take work this cycle
    typedef struct packed {
        logic [ALU_NUM-1:0] alu_free;
        logic [MUL_NUM-1:0] mul_free;
        logic [LSU_NUM-1:0] lsu_free;
    } unit_avail_t;

endpackage

// ==== issue_queue/iq_wakeup.sv ====
`timescale 1ns/1ps

module iq_wakeup import iq_pkg::*; (
    input  iq_item_t [DEPTH-1:0] entries,
    input  iq_item_t             in_item,
    input  wake_bus_t            wake,
    output iq_item_t [DEPTH-1:0] entries_woken,
    output iq_item_t             in_item_woken
);

    // lowest indexed matching channel supplies the value
    function automatic operand_t wake_operand(input operand_t src, input wake_bus_t bus);
        operand_t res;
        logic     hit;
        res = src;
        hit = 1'b0;
        for (int c = 0; c < WAKE_WIDTH; c++) begin
            if (!hit && !src.loaded && bus[c].valid && (bus[c].phy == src.phy)) begin
                res.loaded = 1'b1;
                res.value = bus[c].value;
                hit = 1'b1;
            end
        end
        return res;
    endfunction

    function automatic iq_item_t wake_item(input iq_item_t item, input wake_bus_t bus);
        iq_item_t res;
        res = item;
        res.src1 = wake_operand(item.src1, bus);
        res.src2 = wake_operand(item.src2, bus);
        return res;
    endfunction

    // every slot is woken whether it holds a valid entry or not
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entries_woken[i] = wake_item(entries[i], wake);
        end
    end

    // a broadcast in the insert cycle must not be lost by the new entry
    assign in_item_woken = wake_item(in_item, wake);

endmodule

// ==== issue_queue/iq_storage.sv ====
`timescale 1ns/1ps

module iq_storage import iq_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  iq_item_t [DEPTH-1:0] entries_woken,
    input  iq_item_t             in_item_woken,
    input  logic                 in_valid,
    input  logic [DEPTH-1:0]     issue_mask,
    output iq_item_t [DEPTH-1:0] entries,
    output logic [DEPTH-1:0]     entry_valid,
    output logic                 in_ready
);

    iq_item_t [DEPTH-1:0]            entries_q;
    iq_item_t [DEPTH-1:0]            entries_d;
    logic [DEPTH_W-1:0]              count_q;
    logic [DEPTH_W-1:0]              count_d;
    logic [DEPTH_W-1:0]              survivors;
    logic [DEPTH-1:0]                keep;
    logic [DEPTH-1:0][IDX_W-1:0]     map_src;
    logic [DEPTH-1:0]                map_valid;
    logic                            accept;

    assign entries = entries_q;

    // valid entries are always packed at the low indices
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entry_valid[i] = (DEPTH_W'(i) < count_q);
        end
    end

    // issues of this cycle do not free space early
    assign in_ready = (count_q < DEPTH_W'(DEPTH));
    assign accept = in_valid && in_ready && !flush;

    // destination to source map where survivors keep their relative order
    always_comb begin
        keep = entry_valid & ~issue_mask;
        survivors = '0;
        map_src = '0;
        map_valid = '0;
        for (int j = 0; j < DEPTH; j++) begin
            if (keep[j]) begin
                map_src[IDX_W'(survivors)] = IDX_W'(j);
                map_valid[IDX_W'(survivors)] = 1'b1;
                survivors = survivors + DEPTH_W'(1);
            end
        end
    end

    // shifted survivors first and the accepted item right behind them
    always_comb begin
        for (int d = 0; d < DEPTH; d++) begin
            if (map_valid[d]) begin
                entries_d[d] = entries_woken[map_src[d]];
            end else if (accept && (DEPTH_W'(d) == survivors)) begin
                entries_d[d] = in_item_woken;
            end else begin
                entries_d[d] = entries_q[d];
            end
        end
    end

    assign count_d = survivors + DEPTH_W'(accept);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (flush) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk) begin
        entries_q <= entries_d;
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= DEPTH_W'(DEPTH));

    // select must never pick a slot beyond the occupied range
    a_mask_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_mask & ~entry_valid) == '0);

    a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (count_q == '0));

endmodule

// ==== issue_queue/iq_select.sv ====
`timescale 1ns/1ps

module iq_select import iq_pkg::*; (
    input  iq_item_t [DEPTH-1:0]         entries_woken,
    input  logic [DEPTH-1:0]             entry_valid,
    input  unit_avail_t                  avail,
    output logic [DEPTH-1:0]             issue_mask,
    output iq_item_t [ISSUE_WIDTH-1:0]   issue_item,
    output logic [ISSUE_WIDTH-1:0]       issue_valid
);

    logic [DEPTH_W-1:0]                  alu_left;
    logic [DEPTH_W-1:0]                  mul_left;
    logic [DEPTH_W-1:0]                  lsu_left;
    logic [DEPTH_W-1:0]                  port_cnt;
    logic                                lsu_seen;
    logic                                ready;
    logic                                unit_ok;
    logic [DEPTH-1:0]                    is_lsu;
    logic [ISSUE_WIDTH-1:0][IDX_W-1:0]   port_src;

    // oldest first chain over the queue
    always_comb begin
        alu_left = DEPTH_W'($countones(avail.alu_free));
        mul_left = DEPTH_W'($countones(avail.mul_free));
        lsu_left = DEPTH_W'($countones(avail.lsu_free));
        port_cnt = '0;
        lsu_seen = 1'b0;
        issue_mask = '0;
        issue_valid = '0;
        port_src = '0;
        for (int i = 0; i < DEPTH; i++) begin
            ready = entries_woken[i].src1.loaded && entries_woken[i].src2.loaded;
            is_lsu[i] = (entries_woken[i].unit == lsu);
            case (entries_woken[i].unit)
                alu:     unit_ok = (alu_left != '0);
                mul:     unit_ok = (mul_left != '0);
                // loads and stores leave in program order
                lsu:     unit_ok = (lsu_left != '0) && !lsu_seen;
                default: unit_ok = 1'b0;
            endcase
            if (entry_valid[i] && ready && unit_ok && (port_cnt < DEPTH_W'(ISSUE_WIDTH))) begin
                issue_mask[i] = 1'b1;
                for (int k = 0; k < ISSUE_WIDTH; k++) begin
                    if (port_cnt == DEPTH_W'(k)) begin
                        port_src[k] = IDX_W'(i);
                        issue_valid[k] = 1'b1;
                    end
                end
                port_cnt = port_cnt + DEPTH_W'(1);
                case (entries_woken[i].unit)
                    alu:     alu_left = alu_left - DEPTH_W'(1);
                    mul:     mul_left = mul_left - DEPTH_W'(1);
                    lsu:     lsu_left = lsu_left - DEPTH_W'(1);
                    default: ;
                endcase
            end
            // a waiting lsu blocks every younger lsu whether selected or not
            if (entry_valid[i] && is_lsu[i]) begin
                lsu_seen = 1'b1;
            end
        end
    end

    // k-th selected entry drives port k
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            issue_item[k] = entries_woken[port_src[k]];
        end
    end

    always_comb begin
        a_port_limit: assert final ($countones(issue_mask) <= ISSUE_WIDTH);
        a_single_lsu: assert final ($countones(issue_mask & is_lsu) <= 1);
    end

endmodule

// ==== design/iq_top.sv ====
`timescale 1ns/1ps

module iq_top import iq_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  iq_item_t                     in_item,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  wake_bus_t                    wake,
    input  unit_avail_t                  avail,
    input  logic                         flush,
    output iq_item_t [ISSUE_WIDTH-1:0]   issue_item,
    output logic [ISSUE_WIDTH-1:0]       issue_valid
);

    iq_item_t [DEPTH-1:0] entries;
    iq_item_t [DEPTH-1:0] entries_woken;
    iq_item_t             in_item_woken;
    logic [DEPTH-1:0]     entry_valid;
    logic [DEPTH-1:0]     issue_mask;

    // operand capture for stored entries and the one arriving now
    iq_wakeup u_wakeup (
        .entries       (entries),
        .in_item       (in_item),
        .wake          (wake),
        .entries_woken (entries_woken),
        .in_item_woken (in_item_woken)
    );

    iq_storage u_storage (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .entries_woken (entries_woken),
        .in_item_woken (in_item_woken),
        .in_valid      (in_valid),
        .issue_mask    (issue_mask),
        .entries       (entries),
        .entry_valid   (entry_valid),
        .in_ready      (in_ready)
    );

    iq_select u_select (
        .entries_woken (entries_woken),
        .entry_valid   (entry_valid),
        .avail         (avail),
        .issue_mask    (issue_mask),
        .issue_item    (issue_item),
        .issue_valid   (issue_valid)
    );

endmodule

// ==== tests/tb_iq_top.sv ====
`timescale 1ns/1ps

module tb_iq_top import iq_pkg::*; ();

    localparam int CYCLES = 2000;
    localparam int FILL_EVERY = 400;
    localparam int FILL_TIMEOUT = 40;
    localparam int RESET_TIMEOUT = 10;

    logic                         clk;
    logic                         rst_n;
    iq_item_t                     in_item;
    logic                         in_valid;
    logic                         in_ready;
    wake_bus_t                    wake;
    unit_avail_t                  avail;
    logic                         flush;
    iq_item_t [ISSUE_WIDTH-1:0]   issue_item;
    logic [ISSUE_WIDTH-1:0]       issue_valid;

    integer   seed;
    int       errors;
    int       checks;
    logic     held;
    iq_item_t model_q[$];

    iq_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_item     (in_item),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .wake        (wake),
        .avail       (avail),
        .flush       (flush),
        .issue_item  (issue_item),
        .issue_valid (issue_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // tags come from a pool of 8 so that wakeups hit often
    function automatic logic [PHY_W-1:0] pool_tag(input int r);
        return PHY_W'(8 + (r & 7));
    endfunction

    function automatic logic chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    function automatic operand_t random_operand();
        operand_t op;
        int       r;
        r = $random(seed);
        op.loaded = r[0];
        op.phy = pool_tag($random(seed));
        op.value = $random(seed);
        return op;
    endfunction

    function automatic iq_item_t random_item();
        iq_item_t it;
        int       r;
        r = $random(seed);
        it.rob_id = ROB_W'(r);
        r = $random(seed);
        it.unit = op_unit_t'(2'($unsigned(r) % 3));
        it.src1 = random_operand();
        it.src2 = random_operand();
        return it;
    endfunction

    // pending operand takes the value of the lowest valid channel with its tag
    function automatic operand_t apply_wake(input operand_t op);
        operand_t res;
        res = op;
        if (!op.loaded) begin
            for (int c = WAKE_WIDTH - 1; c >= 0; c--) begin
                if (wake[c].valid && (wake[c].phy == op.phy)) begin
                    res.loaded = 1'b1;
                    res.value = wake[c].value;
                end
            end
        end
        return res;
    endfunction

    function automatic iq_item_t wake_entry(input iq_item_t it);
        iq_item_t res;
        res = it;
        res.src1 = apply_wake(it.src1);
        res.src2 = apply_wake(it.src2);
        return res;
    endfunction

    function automatic int free_count(input op_unit_t u);
        case (u)
            alu:     return $countones(avail.alu_free);
            mul:     return $countones(avail.mul_free);
            lsu:     return $countones(avail.lsu_free);
            default: return 0;
        endcase
    endfunction

    task automatic check_item(input int port, input iq_item_t exp, input iq_item_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] issue_item[%0d] expected %h actual %h", port, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // fill mode keeps the producer busy and starves every unit class
    task automatic drive_inputs(input logic fill);
        int r;
        if (!held) begin
            in_item = random_item();
        end
        in_valid = fill || held || chance(60);
        for (int c = 0; c < WAKE_WIDTH; c++) begin
            wake[c].valid = chance(25);
            wake[c].phy = pool_tag($random(seed));
            wake[c].value = $random(seed);
        end
        if (fill) begin
            avail = '0;
        end else begin
            r = $random(seed);
            avail = r[3:0];
        end
        flush = !fill && chance(1);
    endtask

    // expected issue list for this cycle and the state after the edge
    task automatic model_cycle();
        iq_item_t offered;
        iq_item_t next_q[$];
        int       sel[$];
        int       used[3];
        logic     picked[DEPTH];
        logic     older_lsu;
        logic     accepted;
        iq_item_t e;
        int       u;
        for (int i = 0; i < DEPTH; i++) begin
            picked[i] = 1'b0;
        end
        for (int i = 0; i < 3; i++) begin
            used[i] = 0;
        end
        for (int i = 0; i < model_q.size(); i++) begin
            model_q[i] = wake_entry(model_q[i]);
        end
        offered = wake_entry(in_item);
        older_lsu = 1'b0;
        for (int i = 0; i < model_q.size(); i++) begin
            e = model_q[i];
            u = int'(e.unit);
            if (e.src1.loaded && e.src2.loaded && (sel.size() < ISSUE_WIDTH) &&
                (used[u] < free_count(e.unit)) && !((e.unit == lsu) && older_lsu)) begin
                sel.push_back(i);
                used[u]++;
                picked[i] = 1'b1;
            end
            if (e.unit == lsu) begin
                older_lsu = 1'b1;
            end
        end
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            check_flag($sformatf("issue_valid[%0d]", k), k < sel.size(), issue_valid[k]);
            if ((k < sel.size()) && issue_valid[k]) begin
                check_item(k, model_q[sel[k]], issue_item[k]);
            end
        end
        check_flag("in_ready", model_q.size() < DEPTH, in_ready);
        accepted = in_valid && (model_q.size() < DEPTH) && !flush;
        if (flush) begin
            model_q.delete();
        end else begin
            for (int i = 0; i < model_q.size(); i++) begin
                if (!picked[i]) begin
                    next_q.push_back(model_q[i]);
                end
            end
            if (accepted) begin
                next_q.push_back(offered);
            end
            model_q = next_q;
        end
        held = in_valid && !accepted && !flush;
    endtask

    task automatic step(input logic fill);
        @(negedge clk);
        drive_inputs(fill);
        #2;
        model_cycle();
    endtask

    task automatic fill_queue();
        int n;
        n = 0;
        while ((model_q.size() < DEPTH) && (n < FILL_TIMEOUT)) begin
            step(1'b1);
            n++;
        end
        if (model_q.size() < DEPTH) begin
            errors++;
            $display("fill phase timed out before the queue became full");
        end
        // stay full for a while so in_ready is seen low
        repeat (3) step(1'b1);
    endtask

    initial begin
        int n;
        seed = 66443;
        errors = 0;
        checks = 0;
        held = 1'b0;
        rst_n = 1'b0;
        in_item = '0;
        in_valid = 1'b0;
        wake = '0;
        avail = '0;
        flush = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        n = 0;
        while (!in_ready && (n < RESET_TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            errors++;
            $display("in_ready never went high after reset");
        end
        for (int cyc = 0; cyc < CYCLES; cyc++) begin
            if ((cyc % FILL_EVERY) == 100) begin
                fill_queue();
            end
            step(1'b0);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/iq_pkg.sv
issue_queue/iq_wakeup.sv
issue_queue/iq_storage.sv
issue_queue/iq_select.sv
design/iq_top.sv
tests/tb_iq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_iq_top -Mdir obj_dir -o sim_iq
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_iq > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
